// File: int8_mm_pkg.sv
package int8_mm_pkg;

    localparam int in_width    = 16;   // activation and weight element
    localparam int in_size     = 4;    // cols per beat, rows of weight column
    localparam int in_rows     = 2;    // rows per beat
    localparam int in_elems    = in_rows * in_size;
    localparam int in_depth    = 2;    // beats per result
    localparam int quant_width = 8;
    localparam int max_large   = 10;   // outliers kept per beat
    localparam int large_thres = 127;  // strictly above is an outlier
    localparam int out_width   = 32;

    localparam int q_max = 2 ** (quant_width - 1) - 1;
    localparam int q_min = -(2 ** (quant_width - 1));

    typedef logic signed [in_width-1:0]    elem_t;
    typedef logic signed [quant_width-1:0] q_t;
    typedef logic signed [out_width-1:0]   acc_t;

    typedef enum logic {path_wide = 1'b0, path_int8 = 1'b1} path_e;

    typedef enum logic {st_accum = 1'b0, st_hold = 1'b1} mm_state_e;

    // clamp to int8 range
    function automatic q_t sat_q(elem_t x);
        if (x > q_max) return q_t'(q_max);
        if (x < q_min) return q_t'(q_min);
        return q_t'(x);
    endfunction

    function automatic logic is_outlier(elem_t x);
        return (x > large_thres) || (x < -large_thres);
    endfunction

endpackage

// File: stream_fork.sv
module stream_fork (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [1:0] out_valid,  // bit per path_e
    input  logic [1:0] out_ready
);
    import int8_mm_pkg::*;

    logic [1:0] accepted;  // branch already took the current item

    always_comb begin
        out_valid[path_wide] = in_valid && !accepted[path_wide];
        out_valid[path_int8] = in_valid && !accepted[path_int8];
        // done once each branch has taken it, earlier or now
        in_ready = (accepted[path_wide] || out_ready[path_wide]) &&
                   (accepted[path_int8] || out_ready[path_int8]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            accepted <= '0;
        end else if (in_ready) begin
            accepted <= '0;  // item fully consumed
        end else begin
            accepted <= accepted | (out_valid & out_ready);
        end
    end

    // upstream keeps offering until both branches have it
    a_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid);

endmodule

// File: outlier_scatter.sv
module outlier_scatter (
    input  logic               clk,
    input  logic               arst_n,
    input  int8_mm_pkg::elem_t data_in [int8_mm_pkg::in_elems-1:0],
    input  logic               data_in_valid,
    output logic               data_in_ready,
    output int8_mm_pkg::elem_t data_large [int8_mm_pkg::in_elems-1:0],
    output int8_mm_pkg::elem_t data_small [int8_mm_pkg::in_elems-1:0],
    output logic               scat_sat,
    output logic               scat_valid,
    input  logic               scat_ready
);
    import int8_mm_pkg::*;

    elem_t large_c [in_elems-1:0];
    elem_t small_c [in_elems-1:0];
    logic  sat_c;
    int    n_large;  // outliers routed so far in this beat

    // scan in index order, first max_large outliers go wide
    always_comb begin
        n_large = 0;
        sat_c = 1'b0;
        for (int i = 0; i < in_elems; i++) begin
            if (is_outlier(data_in[i]) && (n_large < max_large)) begin
                large_c[i] = data_in[i];
                small_c[i] = '0;
                n_large = n_large + 1;
            end else begin
                large_c[i] = '0;
                small_c[i] = sat_q(data_in[i]);  // sign extended back
                if (small_c[i] != data_in[i]) begin
                    sat_c = 1'b1;  // overflow outlier got clamped
                end
            end
        end
    end

    assign data_in_ready = !scat_valid || scat_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scat_valid <= 1'b0;
        end else if (data_in_ready) begin
            scat_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            data_large <= large_c;
            data_small <= small_c;
            scat_sat   <= sat_c;
        end
    end

    for (genvar i = 0; i < in_elems; i++) begin : g_chk
        a_small_range: assert property (@(posedge clk) disable iff (!arst_n)
            scat_valid |-> (data_small[i] <= q_max) && (data_small[i] >= q_min));

        // held beat must not change under back-pressure
        a_hold: assert property (@(posedge clk) disable iff (!arst_n)
            scat_valid && !scat_ready |=>
                $stable(data_large[i]) && $stable(data_small[i]) && $stable(scat_sat));
    end

endmodule

// File: wide_matmul.sv
module wide_matmul (
    input  logic               clk,
    input  logic               arst_n,
    input  int8_mm_pkg::elem_t act [int8_mm_pkg::in_elems-1:0],
    input  logic               act_valid,
    output logic               act_ready,
    input  int8_mm_pkg::elem_t wgt [int8_mm_pkg::in_size-1:0],
    input  logic               wgt_valid,
    output logic               wgt_ready,
    output int8_mm_pkg::acc_t  res [int8_mm_pkg::in_rows-1:0],
    output logic               res_valid,
    input  logic               res_ready
);
    import int8_mm_pkg::*;

    mm_state_e                     state;
    logic [$clog2(in_depth+1)-1:0] beat_cnt;
    acc_t                          acc [in_rows-1:0];
    acc_t                          dot [in_rows-1:0];  // products of current beat
    logic                          take;

    // act and weight go in together, partner only seen through its valid
    assign act_ready = (state == st_accum) && wgt_valid;
    assign wgt_ready = (state == st_accum) && act_valid;
    assign take      = (state == st_accum) && act_valid && wgt_valid;

    assign res_valid = (state == st_hold);
    assign res       = acc;

    // full 16x16 products, sign extended before multiply
    always_comb begin
        for (int r = 0; r < in_rows; r++) begin
            dot[r] = '0;
            for (int c = 0; c < in_size; c++) begin
                dot[r] = dot[r] + acc_t'(act[r*in_size+c]) * acc_t'(wgt[c]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_accum;
            beat_cnt <= '0;
            for (int r = 0; r < in_rows; r++) begin
                acc[r] <= '0;
            end
        end else begin
            case (state)
                st_accum: begin
                    if (take) begin
                        for (int r = 0; r < in_rows; r++) begin
                            acc[r] <= acc[r] + dot[r];
                        end
                        if (beat_cnt == in_depth - 1) begin
                            beat_cnt <= '0;
                            state    <= st_hold;  // result valid from next cycle
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                st_hold: begin
                    if (res_ready) begin
                        for (int r = 0; r < in_rows; r++) begin
                            acc[r] <= '0;
                        end
                        state <= st_accum;
                    end
                end
                default: state <= st_accum;
            endcase
        end
    end

endmodule

// File: int8_matmul.sv
module int8_matmul (
    input  logic               clk,
    input  logic               arst_n,
    input  int8_mm_pkg::elem_t act [int8_mm_pkg::in_elems-1:0],
    input  logic               act_valid,
    output logic               act_ready,
    input  logic               sat_in,
    input  int8_mm_pkg::elem_t wgt [int8_mm_pkg::in_size-1:0],
    input  logic               wgt_valid,
    output logic               wgt_ready,
    output int8_mm_pkg::acc_t  res [int8_mm_pkg::in_rows-1:0],
    output logic               res_valid,
    output logic               clipped,
    input  logic               res_ready
);
    import int8_mm_pkg::*;

    mm_state_e                     state;
    logic [$clog2(in_depth+1)-1:0] beat_cnt;
    acc_t                          acc [in_rows-1:0];
    acc_t                          dot [in_rows-1:0];
    q_t                            act_q [in_elems-1:0];
    q_t                            wgt_q [in_size-1:0];
    logic                          wgt_sat;  // some weight clamped this beat
    logic                          take;

    assign act_ready = (state == st_accum) && wgt_valid;
    assign wgt_ready = (state == st_accum) && act_valid;
    assign take      = (state == st_accum) && act_valid && wgt_valid;

    assign res_valid = (state == st_hold);
    assign res       = acc;

    always_comb begin
        wgt_sat = 1'b0;
        for (int c = 0; c < in_size; c++) begin
            wgt_q[c] = sat_q(wgt[c]);
            if (wgt_q[c] != wgt[c]) begin
                wgt_sat = 1'b1;
            end
        end
        for (int i = 0; i < in_elems; i++) begin
            act_q[i] = q_t'(act[i]);  // upper byte is only sign
        end
        // int8 x int8 products
        for (int r = 0; r < in_rows; r++) begin
            dot[r] = '0;
            for (int c = 0; c < in_size; c++) begin
                dot[r] = dot[r] + acc_t'(act_q[r*in_size+c]) * acc_t'(wgt_q[c]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_accum;
            beat_cnt <= '0;
            clipped  <= 1'b0;
            for (int r = 0; r < in_rows; r++) begin
                acc[r] <= '0;
            end
        end else begin
            case (state)
                st_accum: begin
                    if (take) begin
                        for (int r = 0; r < in_rows; r++) begin
                            acc[r] <= acc[r] + dot[r];
                        end
                        clipped <= clipped || sat_in || wgt_sat;  // sticky per transaction
                        if (beat_cnt == in_depth - 1) begin
                            beat_cnt <= '0;
                            state    <= st_hold;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                st_hold: begin
                    if (res_ready) begin
                        for (int r = 0; r < in_rows; r++) begin
                            acc[r] <= '0;
                        end
                        clipped <= 1'b0;
                        state   <= st_accum;
                    end
                end
                default: state <= st_accum;
            endcase
        end
    end

    // scatter must have clamped everything routed here
    for (genvar i = 0; i < in_elems; i++) begin : g_chk
        a_act_range: assert property (@(posedge clk) disable iff (!arst_n)
            act_valid |-> (act[i] <= q_max) && (act[i] >= q_min));
    end

endmodule

// File: gather_join.sv
module gather_join (
    input  logic              clk,
    input  logic              arst_n,
    input  int8_mm_pkg::acc_t wide_sum [int8_mm_pkg::in_rows-1:0],
    input  logic              wide_valid,
    output logic              wide_ready,
    input  int8_mm_pkg::acc_t int8_sum [int8_mm_pkg::in_rows-1:0],
    input  logic              int8_clipped,
    input  logic              int8_valid,
    output logic              int8_ready,
    output int8_mm_pkg::acc_t data_out [int8_mm_pkg::in_rows-1:0],
    output logic              data_out_clipped,
    output logic              data_out_valid,
    input  logic              data_out_ready
);
    import int8_mm_pkg::*;

    logic take;  // both partials land together

    assign take       = wide_valid && int8_valid && (!data_out_valid || data_out_ready);
    assign wide_ready = take;
    assign int8_ready = take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out_valid <= 1'b0;
        end else if (take) begin
            data_out_valid <= 1'b1;
        end else if (data_out_ready) begin
            data_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            for (int r = 0; r < in_rows; r++) begin
                data_out[r] <= wide_sum[r] + int8_sum[r];
            end
            data_out_clipped <= int8_clipped;
        end
    end

    // a path result not yet taken stays offered until its partner arrives
    a_wide_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wide_valid && !wide_ready |=> wide_valid);

    a_int8_hold: assert property (@(posedge clk) disable iff (!arst_n)
        int8_valid && !int8_ready |=> int8_valid);

endmodule

// File: mixed_matmul_top.sv
module mixed_matmul_top (
    input  logic               clk,
    input  logic               arst_n,
    input  int8_mm_pkg::elem_t data_in [int8_mm_pkg::in_elems-1:0],
    input  logic               data_in_valid,
    output logic               data_in_ready,
    input  int8_mm_pkg::elem_t weight [int8_mm_pkg::in_size-1:0],
    input  logic               weight_valid,
    output logic               weight_ready,
    output int8_mm_pkg::acc_t  data_out [int8_mm_pkg::in_rows-1:0],
    output logic               data_out_clipped,
    output logic               data_out_valid,
    input  logic               data_out_ready
);
    import int8_mm_pkg::*;

    elem_t      data_large [in_elems-1:0];
    elem_t      data_small [in_elems-1:0];
    logic       scat_sat;
    logic       scat_valid;
    logic       scat_ready;
    logic [1:0] act_valid;  // indexed by path_e
    logic [1:0] act_ready;
    logic [1:0] wgt_valid;
    logic [1:0] wgt_ready;
    acc_t       wide_sum [in_rows-1:0];
    acc_t       int8_sum [in_rows-1:0];
    logic       int8_clipped;
    logic       wide_valid;
    logic       wide_ready;
    logic       int8_valid;
    logic       int8_ready;

    outlier_scatter u_scatter (
        .clk(clk), .arst_n(arst_n),
        .data_in(data_in), .data_in_valid(data_in_valid), .data_in_ready(data_in_ready),
        .data_large(data_large), .data_small(data_small), .scat_sat(scat_sat),
        .scat_valid(scat_valid), .scat_ready(scat_ready)
    );

    stream_fork act_fork (
        .clk(clk), .arst_n(arst_n),
        .in_valid(scat_valid), .in_ready(scat_ready),
        .out_valid(act_valid), .out_ready(act_ready)
    );

    stream_fork wgt_fork (
        .clk(clk), .arst_n(arst_n),
        .in_valid(weight_valid), .in_ready(weight_ready),
        .out_valid(wgt_valid), .out_ready(wgt_ready)
    );

    wide_matmul u_wide (
        .clk(clk), .arst_n(arst_n),
        .act(data_large), .act_valid(act_valid[path_wide]), .act_ready(act_ready[path_wide]),
        .wgt(weight), .wgt_valid(wgt_valid[path_wide]), .wgt_ready(wgt_ready[path_wide]),
        .res(wide_sum), .res_valid(wide_valid), .res_ready(wide_ready)
    );

    int8_matmul u_int8 (
        .clk(clk), .arst_n(arst_n),
        .act(data_small), .act_valid(act_valid[path_int8]), .act_ready(act_ready[path_int8]),
        .sat_in(scat_sat),
        .wgt(weight), .wgt_valid(wgt_valid[path_int8]), .wgt_ready(wgt_ready[path_int8]),
        .res(int8_sum), .res_valid(int8_valid), .clipped(int8_clipped),
        .res_ready(int8_ready)
    );

    gather_join u_gather (
        .clk(clk), .arst_n(arst_n),
        .wide_sum(wide_sum), .wide_valid(wide_valid), .wide_ready(wide_ready),
        .int8_sum(int8_sum), .int8_clipped(int8_clipped),
        .int8_valid(int8_valid), .int8_ready(int8_ready),
        .data_out(data_out), .data_out_clipped(data_out_clipped),
        .data_out_valid(data_out_valid), .data_out_ready(data_out_ready)
    );

endmodule

// File: tb_mixed_matmul.sv
module tb_mixed_matmul;
    import int8_mm_pkg::*;

    localparam int max_beats = 32;
    localparam int max_res   = 16;
    localparam int limit     = 500;  // cycles allowed per wait

    logic  clk;
    logic  arst_n;
    elem_t data_in [in_elems-1:0];
    logic  data_in_valid;
    logic  data_in_ready;
    elem_t weight [in_size-1:0];
    logic  weight_valid;
    logic  weight_ready;
    acc_t  data_out [in_rows-1:0];
    logic  data_out_clipped;
    logic  data_out_valid;
    logic  data_out_ready;

    elem_t act_mem [max_beats*in_elems];
    elem_t wgt_mem [max_beats*in_size];
    acc_t  exp_mem [max_res*in_rows];
    logic  exp_clip [max_res];
    string res_name [max_res];
    acc_t  model_out [in_rows];
    logic  model_clip;
    acc_t  held_out [in_rows];  // output seen while stalled
    logic  held_clip;
    logic  held = 1'b0;
    bit    aborted = 1'b0;
    int    seed = 68187;
    int    n_beats = 0;
    int    n_res = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    n_tests = 0;
    int    n_bad = 0;

    mixed_matmul_top DUT (
        .clk(clk), .arst_n(arst_n),
        .data_in(data_in), .data_in_valid(data_in_valid), .data_in_ready(data_in_ready),
        .weight(weight), .weight_valid(weight_valid), .weight_ready(weight_ready),
        .data_out(data_out), .data_out_clipped(data_out_clipped),
        .data_out_valid(data_out_valid), .data_out_ready(data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_acc(input acc_t got, input acc_t exp, input string name);
        if (got !== exp) begin
            $display("ERR %0t %s got=%0d exp=%0d", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERR %0t %s got=%b exp=%b", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_errs == 0) begin
            $display("test %-18s ok", name);
        end else begin
            n_bad++;
            $display("test %-18s bad, %0d errors", name, test_errs);
        end
    endtask

    function automatic int clamp8(input int v);
        if (v > 127) return 127;
        if (v < -128) return -128;
        return v;
    endfunction

    task automatic load_golden();
        int fd;
        int code;
        bit short_rec;
        string tok;
        string line;
        logic [31:0] v;
        short_rec = 1'b0;
        fd = $fopen("mixed_matmul_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open mixed_matmul_golden.txt");
            errors++;
            return;
        end
        while (n_beats < max_beats && n_res < max_res && $fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                code = $fgets(line, fd);  // rest of a comment line
            end else if (tok == "B") begin
                for (int i = 0; i < in_elems + in_size; i++) begin
                    code = $fscanf(fd, "%h", v);
                    if (code != 1) short_rec = 1'b1;
                    if (i < in_elems) act_mem[n_beats*in_elems+i] = v[15:0];
                    else wgt_mem[n_beats*in_size+i-in_elems] = v[15:0];
                end
                n_beats++;
            end else if (tok == "E") begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) short_rec = 1'b1;
                res_name[n_res] = tok;
                for (int r = 0; r < in_rows; r++) begin
                    code = $fscanf(fd, "%h", v);
                    if (code != 1) short_rec = 1'b1;
                    exp_mem[n_res*in_rows+r] = v;
                end
                code = $fscanf(fd, "%h", v);
                if (code != 1) short_rec = 1'b1;
                exp_clip[n_res] = v[0];
                n_res++;
            end else begin
                $display("unknown record %s in golden file", tok);
                errors++;
            end
        end
        $fclose(fd);
        if (short_rec) begin
            $display("golden file holds a short or unreadable record");
            errors++;
        end
    endtask

    // expected sums from the outlier split and int8 clamp rules
    task automatic model_result(input int k);
        int rsum [in_rows];
        int b;
        int a;
        int w;
        int n_out;
        model_clip = 1'b0;
        for (int r = 0; r < in_rows; r++) rsum[r] = 0;
        for (int d = 0; d < in_depth; d++) begin
            b = k * in_depth + d;
            n_out = 0;
            for (int c = 0; c < in_size; c++) begin
                if (clamp8(wgt_mem[b*in_size+c]) != wgt_mem[b*in_size+c]) model_clip = 1'b1;
            end
            for (int i = 0; i < in_elems; i++) begin
                a = act_mem[b*in_elems+i];
                w = wgt_mem[b*in_size+(i % in_size)];
                if ((a > 127 || a < -127) && n_out < 10) begin
                    n_out++;
                    rsum[i/in_size] += a * w;  // full precision
                end else begin
                    if (clamp8(a) != a) model_clip = 1'b1;
                    rsum[i/in_size] += clamp8(a) * clamp8(w);
                end
            end
        end
        for (int r = 0; r < in_rows; r++) model_out[r] = rsum[r];
    endtask

    task automatic check_golden();
        bit bad;
        test_errs = 0;
        if (n_res == 0 || n_beats != n_res * in_depth) begin
            $display("golden file holds %0d beats for %0d results", n_beats, n_res);
            errors++;
            test_errs++;
        end else begin
            for (int k = 0; k < n_res; k++) begin
                model_result(k);
                bad = (model_clip !== exp_clip[k]);
                for (int r = 0; r < in_rows; r++) begin
                    if (model_out[r] !== exp_mem[k*in_rows+r]) bad = 1'b1;
                end
                if (bad) begin
                    $display("golden record %0d (%s) disagrees with the rules", k, res_name[k]);
                    errors++;
                    test_errs++;
                end
            end
        end
        end_test("golden_vs_model");
    endtask

    task automatic check_idle(input string name);
        test_errs = 0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            data_out_ready = 1'b1;
            #1;
            check_flag(data_out_valid, 1'b0, "data_out_valid");
        end
        end_test(name);
    endtask

    // data and weight handshake independently before the next beat
    task automatic send_beat(input int b);
        bit d_done;
        bit w_done;
        int n;
        d_done = 1'b0;
        w_done = 1'b0;
        n = 0;
        while (!(d_done && w_done) && !aborted) begin
            @(negedge clk);
            if (n == 0) begin
                for (int i = 0; i < in_elems; i++) data_in[i] = act_mem[b*in_elems+i];
                for (int c = 0; c < in_size; c++) weight[c] = wgt_mem[b*in_size+c];
            end
            data_in_valid = !d_done;
            weight_valid = !w_done;
            #1;  // readies settle well before the rising edge
            if (data_in_valid && data_in_ready) d_done = 1'b1;
            if (weight_valid && weight_ready) w_done = 1'b1;
            n++;
            if (!(d_done && w_done) && n >= limit) begin
                if (!d_done) $display("timeout waiting for data_in_ready");
                if (!w_done) $display("timeout waiting for weight_ready");
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic drive_beats();
        int gap;
        for (int b = 0; b < n_beats && !aborted; b++) begin
            gap = $urandom % 3;
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
                data_in_valid = 1'b0;
                weight_valid = 1'b0;
            end
            send_beat(b);
        end
        @(negedge clk);
        data_in_valid = 1'b0;
        weight_valid = 1'b0;
    endtask

    task automatic wait_result(input int k);
        int n;
        bit got;
        path_e p;
        n = 0;
        got = 1'b0;
        while (!got && !aborted) begin
            @(negedge clk);
            data_out_ready = ($urandom % 4) != 0;  // low about a quarter of cycles
            #1;
            if (held) begin
                check_flag(data_out_valid, 1'b1, "data_out_valid");
                check_flag(data_out_clipped, held_clip, "data_out_clipped");
                for (int r = 0; r < in_rows; r++) begin
                    check_acc(data_out[r], held_out[r], $sformatf("data_out[%0d]", r));
                end
            end
            held = data_out_valid && !data_out_ready;
            held_clip = data_out_clipped;
            for (int r = 0; r < in_rows; r++) held_out[r] = data_out[r];
            if (data_out_valid && data_out_ready) begin
                got = 1'b1;
                for (int r = 0; r < in_rows; r++) begin
                    check_acc(data_out[r], exp_mem[k*in_rows+r], $sformatf("data_out[%0d]", r));
                end
                check_flag(data_out_clipped, exp_clip[k], "data_out_clipped");
            end
            n++;
            if (!got && n >= limit) begin
                $display("timeout waiting for data_out_valid");
                p = path_wide;
                if (!DUT.wide_valid) $display("no result from the %s path", p.name());
                p = path_int8;
                if (!DUT.int8_valid) $display("no result from the %s path", p.name());
                errors++;
                test_errs++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic collect_results();
        for (int k = 0; k < n_res && !aborted; k++) begin
            test_errs = 0;
            wait_result(k);
            end_test(res_name[k]);
        end
    endtask

    initial begin
        void'($urandom(seed));
        arst_n = 1'b0;
        data_in_valid = 1'b0;
        weight_valid = 1'b0;
        data_out_ready = 1'b0;
        for (int i = 0; i < in_elems; i++) data_in[i] = '0;
        for (int c = 0; c < in_size; c++) weight[c] = '0;
        load_golden();
        check_golden();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_idle("idle_after_reset");
        fork
            drive_beats();
            collect_results();
        join
        check_idle("no_extra_output");  // nothing beyond the golden records
        $display("%0d tests, %0d bad, %0d errors", n_tests, n_bad, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
int8_mm_pkg.sv
stream_fork.sv
outlier_scatter.sv
wide_matmul.sv
int8_matmul.sv
gather_join.sv
mixed_matmul_top.sv
tb_mixed_matmul.sv

// File: mixed_matmul_golden.txt
# B: 8 activations (2x4 row-major) then 4 weights, 16-bit hex
# E: test name, expected data_out[0] data_out[1] (32-bit hex), clipped flag
B 0001 0002 0003 0004 0005 0006 0007 0008 0001 0001 0001 0001
B ffff fffe fffd fffc 000a 0014 001e 0028 0002 ffff 0003 0000
E no_outliers 00000001 00000074 0
B 0080 ff80 007f ff81 03e8 fc18 0000 0005 0003 0002 0001 0004
B 00c8 0000 0000 0000 0000 0000 0000 fed4 0064 0000 0000 0032
E thresholds 00004d23 ffffc964 0
B 012c fed4 0100 ff00 0082 008c ff6a 00a0 0001 0001 0001 0001
B 03e8 03e8 03e8 03e8 ff38 ff38 ff38 ff38 000a 0014 001e 0028
E all_outliers 000186a0 ffffb2f8 0
B 0001 0002 0000 0000 0003 0000 0000 ffff 00c8 0005 0000 fed4
B 01f4 0000 0000 0000 0000 0000 0000 0002 03e8 0000 0000 0007
E wide_weight 0007a1a9 0000020b 1
B ff80 007f ff7f 0040 0000 fffb 0190 0001 fffe 0003 0001 ff38
B 000a 000a 000a 000a fff6 fff6 fff6 fff6 0001 0002 0003 0004
E mixed_sat ffffe260 0000009d 1
B 7fff 8000 0000 0000 0000 0000 0000 0000 7fff 8000 0000 0000
B 0000 0000 0000 0000 0001 0001 0001 0001 0001 0001 0001 0001
E full_range 7fff0001 00000004 1
B 0002 0000 0000 0000 0000 0000 0000 0003 0005 0000 0000 0005
B 0002 0000 0000 0000 0000 0000 0000 0003 0001 0000 0000 0001
E clean_again 0000000c 00000012 0
